//--- hdl/core_ctrl_pkg.sv
//////////////////////////////
// shared widths and enums of the core controller
// import with core_ctrl_pkg::* in the module header
//////////////////////////////

package core_ctrl_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  // data and instruction width
  parameter int unsigned XLEN     = 32;
  // compressed instruction width
  parameter int unsigned CINSN_W  = 16;
  // interrupt id width
  parameter int unsigned IRQ_ID_W = 5;
  // mcause width, top bit marks an interrupt
  parameter int unsigned CAUSE_W  = 6;

  //////////////////////////////
  // enums
  //////////////////////////////

  // fetch address select toward the prefetcher
  typedef enum logic [1:0] {
    PC_BOOT,
    PC_JUMP,
    PC_EXC,
    PC_ERET
  } pc_sel_e;

  // exception vector select
  typedef enum logic {
    EXC_PC_EXC,
    EXC_PC_IRQ
  } exc_pc_sel_e;

  // synchronous exception causes
  // interrupt causes are built as {1'b1, irq id} and are not listed here
  typedef enum logic [CAUSE_W-1:0] {
    EXC_CAUSE_NONE               = 6'd0,
    EXC_CAUSE_ILLEGAL_INSN       = 6'd2,
    EXC_CAUSE_BREAKPOINT         = 6'd3,
    EXC_CAUSE_LOAD_ACCESS_FAULT  = 6'd5,
    EXC_CAUSE_STORE_ACCESS_FAULT = 6'd7,
    EXC_CAUSE_ECALL_MMODE        = 6'd11
  } exc_cause_e;

  // controller FSM states
  typedef enum logic [2:0] {
    RESET,
    BOOT_SET,
    WAIT_SLEEP,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH,
    IRQ_TAKEN
  } ctrl_fsm_e;

endpackage

//--- hdl/exc_cause_if.sv
//////////////////////////////
// exception summary from the cause unit to the FSM
// levels only, valid in the cycle they are driven
//////////////////////////////

`timescale 1ns/1ps

interface exc_cause_if import core_ctrl_pkg::*; ();

  // any event that needs a pipeline flush
  logic             special_req;
  // exception to take in FLUSH
  logic             exc_req;
  // prioritized cause and matching mtval
  exc_cause_e       cause;
  logic [XLEN-1:0]  mtval;
  // special instructions pending in ID
  logic             mret;
  logic             wfi;

  modport cause_mp (output special_req, exc_req, cause, mtval, mret, wfi);
  modport fsm_mp   (input  special_req, exc_req, cause, mtval, mret, wfi);

endinterface

//--- hdl/exc_cause_unit.sv
//////////////////////////////
// classifies decoder and LSU events for the controller
// latches LSU error pulses and picks cause and mtval
//////////////////////////////

`timescale 1ns/1ps

module exc_cause_unit import core_ctrl_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,

  // decoder flags
  input  logic                illegal_insn_i,
  input  logic                ecall_insn_i,
  input  logic                ebrk_insn_i,
  input  logic                mret_insn_i,
  input  logic                wfi_insn_i,
  input  logic                csr_status_i,

  // LSU error pulses and faulting address
  input  logic                load_err_i,
  input  logic                store_err_i,
  input  logic [XLEN-1:0]     lsu_addr_last_i,

  // instruction in ID, for mtval
  input  logic [XLEN-1:0]     instr_i,
  input  logic [CINSN_W-1:0]  instr_compressed_i,
  input  logic                instr_is_compressed_i,

  exc_cause_if.cause_mp       exc_o
);

  logic            load_err_q;
  logic            store_err_q;
  logic            exc_req_insn;
  exc_cause_e      cause;
  logic [XLEN-1:0] mtval;

  // LSU errors arrive in DECODE and are taken in the following FLUSH
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      load_err_q  <= 1'b0;
      store_err_q <= 1'b0;
    end else begin
      load_err_q  <= load_err_i;
      store_err_q <= store_err_i;
    end
  end

  // exceptions raised by the instruction itself
  assign exc_req_insn = illegal_insn_i | ecall_insn_i | ebrk_insn_i;

  // cause priority follows the privileged spec table
  always_comb begin
    cause = EXC_CAUSE_NONE;
    mtval = '0;
    if (illegal_insn_i) begin
      cause = EXC_CAUSE_ILLEGAL_INSN;
      // faulting instruction bits, compressed ones zero-extended
      mtval = instr_is_compressed_i ? {{(XLEN-CINSN_W){1'b0}}, instr_compressed_i} : instr_i;
    end else if (ecall_insn_i) begin
      cause = EXC_CAUSE_ECALL_MMODE;
    end else if (ebrk_insn_i) begin
      cause = EXC_CAUSE_BREAKPOINT;
    end else if (store_err_q) begin
      cause = EXC_CAUSE_STORE_ACCESS_FAULT;
      mtval = lsu_addr_last_i;
    end else if (load_err_q) begin
      cause = EXC_CAUSE_LOAD_ACCESS_FAULT;
      mtval = lsu_addr_last_i;
    end
  end

  // live LSU pulses request the flush, latched ones raise the exception
  assign exc_o.special_req = mret_insn_i | wfi_insn_i | csr_status_i | exc_req_insn |
                             load_err_i | store_err_i;
  assign exc_o.exc_req     = exc_req_insn | load_err_q | store_err_q;
  assign exc_o.cause       = cause;
  assign exc_o.mtval       = mtval;
  assign exc_o.mret        = mret_insn_i;
  assign exc_o.wfi         = wfi_insn_i;

endmodule

//--- hdl/ctrl_fsm.sv
//////////////////////////////
// controller FSM of the core
// drives PC redirects, CSR save strobes and IF-ID stall control
//////////////////////////////

`timescale 1ns/1ps

module ctrl_fsm import core_ctrl_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  input  logic                 fetch_enable_i,
  input  logic                 instr_valid_i,
  input  logic                 branch_set_i,
  input  logic                 jump_set_i,

  // interrupts
  input  logic                 irq_i,
  input  logic                 irq_req_ctrl_i,
  input  logic [IRQ_ID_W-1:0]  irq_id_ctrl_i,
  input  logic                 m_ie_i,

  // multicycle stalls
  input  logic                 stall_lsu_i,
  input  logic                 stall_multdiv_i,
  input  logic                 stall_jump_i,
  input  logic                 stall_branch_i,

  exc_cause_if.fsm_mp          exc_i,

  // core status and IF-ID handling
  output logic                 ctrl_busy_o,
  output logic                 first_fetch_o,
  output logic                 instr_valid_clear_o,
  output logic                 id_in_ready_o,
  output logic                 id_out_valid_o,

  // prefetcher
  output logic                 instr_req_o,
  output logic                 pc_set_o,
  output pc_sel_e              pc_mux_o,
  output exc_pc_sel_e          exc_pc_mux_o,

  // interrupt and exception handshake strobes
  output logic                 irq_ack_o,
  output logic [IRQ_ID_W-1:0]  irq_id_o,
  output logic                 exc_ack_o,
  output exc_cause_e           exc_cause_o,

  // CSR file
  output logic                 csr_save_if_o,
  output logic                 csr_save_id_o,
  output logic                 csr_restore_mret_id_o,
  output logic                 csr_save_cause_o,
  output logic [XLEN-1:0]      csr_mtval_o,

  // performance counters
  output logic                 perf_jump_o,
  output logic                 perf_tbranch_o
);

  ctrl_fsm_e state_q, state_d;

  logic stall;
  logic halt_if;
  logic halt_id;
  logic handle_irq;

  // interrupt only when globally enabled
  assign handle_irq = irq_req_ctrl_i & m_ie_i;

  //////////////////////////////
  // next state and outputs
  //////////////////////////////

  always_comb begin
    state_d               = state_q;
    ctrl_busy_o           = 1'b1;
    first_fetch_o         = 1'b0;
    instr_req_o           = 1'b1;
    pc_set_o              = 1'b0;
    pc_mux_o              = PC_BOOT;
    exc_pc_mux_o          = EXC_PC_EXC;
    exc_cause_o           = EXC_CAUSE_NONE;
    csr_mtval_o           = '0;
    irq_ack_o             = 1'b0;
    exc_ack_o             = 1'b0;
    csr_save_if_o         = 1'b0;
    csr_save_id_o         = 1'b0;
    csr_restore_mret_id_o = 1'b0;
    csr_save_cause_o      = 1'b0;
    perf_jump_o           = 1'b0;
    perf_tbranch_o        = 1'b0;
    halt_if               = 1'b0;
    halt_id               = 1'b0;

    unique case (state_q)
      RESET: begin
        // hold boot address until fetch is enabled
        instr_req_o = 1'b0;
        pc_set_o    = 1'b1;
        pc_mux_o    = PC_BOOT;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end

      BOOT_SET: begin
        pc_set_o = 1'b1;
        pc_mux_o = PC_BOOT;
        state_d  = FIRST_FETCH;
      end

      WAIT_SLEEP, SLEEP: begin
        // core idle, IF and ID frozen
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        halt_id     = 1'b1;
        if (state_q == WAIT_SLEEP) begin
          state_d = SLEEP;
        end else if (irq_i) begin
          // wake on any pending irq, even a masked one
          state_d = FIRST_FETCH;
        end
      end

      FIRST_FETCH: begin
        first_fetch_o = 1'b1;
        // wait out an IF miss
        if (!stall) begin
          state_d = DECODE;
        end
        // pipeline is empty here, take the irq at once
        if (handle_irq) begin
          state_d = IRQ_TAKEN;
          halt_if = 1'b1;
          halt_id = 1'b1;
        end
      end

      DECODE: begin
        if (instr_valid_i) begin
          if (branch_set_i || jump_set_i) begin
            // redirect fetch to the target in the same cycle
            pc_set_o       = 1'b1;
            pc_mux_o       = PC_JUMP;
            perf_tbranch_o = branch_set_i;
            perf_jump_o    = jump_set_i;
          end else if (exc_i.special_req) begin
            state_d = FLUSH;
            halt_if = 1'b1;
            halt_id = 1'b1;
          end
          // keep IF quiet so the irq is not starved by a multicycle instr
          if (handle_irq && stall) begin
            halt_if = 1'b1;
          end
        end
        if (handle_irq && !stall && !exc_i.special_req) begin
          state_d = IRQ_TAKEN;
          halt_if = 1'b1;
          halt_id = 1'b1;
        end
      end

      IRQ_TAKEN: begin
        pc_set_o         = 1'b1;
        pc_mux_o         = PC_EXC;
        exc_pc_mux_o     = EXC_PC_IRQ;
        // interrupt cause has the top bit set
        exc_cause_o      = exc_cause_e'({1'b1, irq_id_ctrl_i});
        csr_save_if_o    = 1'b1;
        csr_save_cause_o = 1'b1;
        irq_ack_o        = 1'b1;
        exc_ack_o        = 1'b1;
        state_d          = DECODE;
      end

      FLUSH: begin
        halt_if = 1'b1;
        halt_id = 1'b1;
        state_d = DECODE;
        if (exc_i.exc_req) begin
          // save ID pc and cause, jump to the trap vector
          pc_set_o         = 1'b1;
          pc_mux_o         = PC_EXC;
          exc_pc_mux_o     = EXC_PC_EXC;
          csr_save_id_o    = 1'b1;
          csr_save_cause_o = 1'b1;
          exc_cause_o      = exc_i.cause;
          csr_mtval_o      = exc_i.mtval;
        end else if (exc_i.mret) begin
          pc_set_o              = 1'b1;
          pc_mux_o              = PC_ERET;
          csr_restore_mret_id_o = 1'b1;
        end else if (exc_i.wfi) begin
          state_d = WAIT_SLEEP;
        end
        // csr status flush only needs the return to DECODE
      end

      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  //////////////////////////////
  // stall control
  //////////////////////////////

  // any multicycle unit still busy with the current instr
  assign stall = stall_lsu_i | stall_multdiv_i | stall_jump_i | stall_branch_i;

  assign id_in_ready_o       = ~stall & ~halt_if;
  // drop the IF-ID entry once done or when flushed
  assign instr_valid_clear_o = ~stall | halt_id;
  assign id_out_valid_o      = ~stall & instr_valid_i;

  assign irq_id_o = irq_id_ctrl_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RESET;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

//--- hdl/core_ctrl.sv
//////////////////////////////
// top level of the core controller
// joins the cause unit and the FSM, plain ports only
//////////////////////////////

`timescale 1ns/1ps

module core_ctrl import core_ctrl_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 fetch_enable_i,

  // decoder
  input  logic                 illegal_insn_i,
  input  logic                 ecall_insn_i,
  input  logic                 ebrk_insn_i,
  input  logic                 mret_insn_i,
  input  logic                 wfi_insn_i,
  input  logic                 csr_status_i,

  // IF-ID register
  input  logic                 instr_valid_i,
  input  logic [XLEN-1:0]      instr_i,
  input  logic [CINSN_W-1:0]   instr_compressed_i,
  input  logic                 instr_is_compressed_i,

  // LSU
  input  logic [XLEN-1:0]      lsu_addr_last_i,
  input  logic                 load_err_i,
  input  logic                 store_err_i,

  // jumps and branches
  input  logic                 branch_set_i,
  input  logic                 jump_set_i,

  // interrupts
  input  logic                 irq_i,
  input  logic                 irq_req_ctrl_i,
  input  logic [IRQ_ID_W-1:0]  irq_id_ctrl_i,
  input  logic                 m_ie_i,

  // stalls
  input  logic                 stall_lsu_i,
  input  logic                 stall_multdiv_i,
  input  logic                 stall_jump_i,
  input  logic                 stall_branch_i,

  // controller outputs
  output logic                 ctrl_busy_o,
  output logic                 first_fetch_o,
  output logic                 instr_valid_clear_o,
  output logic                 id_in_ready_o,
  output logic                 id_out_valid_o,
  output logic                 instr_req_o,
  output logic                 pc_set_o,
  output pc_sel_e              pc_mux_o,
  output exc_pc_sel_e          exc_pc_mux_o,
  output logic                 irq_ack_o,
  output logic [IRQ_ID_W-1:0]  irq_id_o,
  output logic                 exc_ack_o,
  output exc_cause_e           exc_cause_o,
  output logic                 csr_save_if_o,
  output logic                 csr_save_id_o,
  output logic                 csr_restore_mret_id_o,
  output logic                 csr_save_cause_o,
  output logic [XLEN-1:0]      csr_mtval_o,
  output logic                 perf_jump_o,
  output logic                 perf_tbranch_o
);

  // exception summary between the two halves
  exc_cause_if exc_if ();

  exc_cause_unit u_cause (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .illegal_insn_i        (illegal_insn_i),
    .ecall_insn_i          (ecall_insn_i),
    .ebrk_insn_i           (ebrk_insn_i),
    .mret_insn_i           (mret_insn_i),
    .wfi_insn_i            (wfi_insn_i),
    .csr_status_i          (csr_status_i),
    .load_err_i            (load_err_i),
    .store_err_i           (store_err_i),
    .lsu_addr_last_i       (lsu_addr_last_i),
    .instr_i               (instr_i),
    .instr_compressed_i    (instr_compressed_i),
    .instr_is_compressed_i (instr_is_compressed_i),
    .exc_o                 (exc_if.cause_mp)
  );

  ctrl_fsm u_fsm (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .fetch_enable_i        (fetch_enable_i),
    .instr_valid_i         (instr_valid_i),
    .branch_set_i          (branch_set_i),
    .jump_set_i            (jump_set_i),
    .irq_i                 (irq_i),
    .irq_req_ctrl_i        (irq_req_ctrl_i),
    .irq_id_ctrl_i         (irq_id_ctrl_i),
    .m_ie_i                (m_ie_i),
    .stall_lsu_i           (stall_lsu_i),
    .stall_multdiv_i       (stall_multdiv_i),
    .stall_jump_i          (stall_jump_i),
    .stall_branch_i        (stall_branch_i),
    .exc_i                 (exc_if.fsm_mp),
    .ctrl_busy_o           (ctrl_busy_o),
    .first_fetch_o         (first_fetch_o),
    .instr_valid_clear_o   (instr_valid_clear_o),
    .id_in_ready_o         (id_in_ready_o),
    .id_out_valid_o        (id_out_valid_o),
    .instr_req_o           (instr_req_o),
    .pc_set_o              (pc_set_o),
    .pc_mux_o              (pc_mux_o),
    .exc_pc_mux_o          (exc_pc_mux_o),
    .irq_ack_o             (irq_ack_o),
    .irq_id_o              (irq_id_o),
    .exc_ack_o             (exc_ack_o),
    .exc_cause_o           (exc_cause_o),
    .csr_save_if_o         (csr_save_if_o),
    .csr_save_id_o         (csr_save_id_o),
    .csr_restore_mret_id_o (csr_restore_mret_id_o),
    .csr_save_cause_o      (csr_save_cause_o),
    .csr_mtval_o           (csr_mtval_o),
    .perf_jump_o           (perf_jump_o),
    .perf_tbranch_o        (perf_tbranch_o)
  );

endmodule

//--- test/core_ctrl_tb.sv
//////////////////////////////
// trace driven testbench of the core controller
// run from the project root, reads the trace under test/
//////////////////////////////

`timescale 1ns/1ps

module core_ctrl_tb import core_ctrl_pkg::*; ();

  localparam string TRACE_FILE = "test/core_ctrl_trace.txt";

  logic                clk_i;
  logic                rst_ni;
  logic                fetch_enable_i;
  logic                illegal_insn_i, ecall_insn_i, ebrk_insn_i;
  logic                mret_insn_i, wfi_insn_i, csr_status_i;
  logic                instr_valid_i;
  logic [XLEN-1:0]     instr_i;
  logic [CINSN_W-1:0]  instr_compressed_i;
  logic                instr_is_compressed_i;
  logic [XLEN-1:0]     lsu_addr_last_i;
  logic                load_err_i, store_err_i;
  logic                branch_set_i, jump_set_i;
  logic                irq_i, irq_req_ctrl_i, m_ie_i;
  logic [IRQ_ID_W-1:0] irq_id_ctrl_i;
  logic                stall_lsu_i, stall_multdiv_i, stall_jump_i, stall_branch_i;

  logic                ctrl_busy_o, first_fetch_o, instr_valid_clear_o;
  logic                id_in_ready_o, id_out_valid_o, instr_req_o, pc_set_o;
  pc_sel_e             pc_mux_o;
  exc_pc_sel_e         exc_pc_mux_o;
  logic                irq_ack_o, exc_ack_o;
  logic [IRQ_ID_W-1:0] irq_id_o;
  exc_cause_e          exc_cause_o;
  logic                csr_save_if_o, csr_save_id_o, csr_restore_mret_id_o;
  logic                csr_save_cause_o;
  logic [XLEN-1:0]     csr_mtval_o;
  logic                perf_jump_o, perf_tbranch_o;

  // input fields of one trace line
  logic [3:0]  f_ctl;
  logic [6:0]  f_dec;
  logic [1:0]  f_lsu;
  logic [2:0]  f_irq;
  logic [3:0]  f_stall;
  logic [4:0]  f_id;
  logic [31:0] f_instr;
  logic [15:0] f_cinstr;
  logic [31:0] f_addr;
  // expected fields of one trace line
  logic        e_pcset;
  logic [1:0]  e_pcmux;
  logic        e_excpc;
  logic [5:0]  e_cause;
  logic [31:0] e_mtval;
  logic [11:0] e_strb;
  logic        e_rdy;
  logic        e_busy;

  string lines[$];
  int    checks       = 0;
  int    mismatches   = 0;
  int    other_errors = 0;
  int    cycle_cnt    = 0;
  int    limit_cycles = 0;

  core_ctrl dut0 (.*);

  // 100 ns clock
  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic init_inputs();
    fetch_enable_i        = 1'b0;
    {illegal_insn_i, ecall_insn_i, ebrk_insn_i} = 3'b000;
    {mret_insn_i, wfi_insn_i, csr_status_i}     = 3'b000;
    instr_valid_i         = 1'b0;
    instr_i               = '0;
    instr_compressed_i    = '0;
    instr_is_compressed_i = 1'b0;
    lsu_addr_last_i       = '0;
    {load_err_i, store_err_i}     = 2'b00;
    {branch_set_i, jump_set_i}    = 2'b00;
    {irq_i, irq_req_ctrl_i, m_ie_i} = 3'b000;
    irq_id_ctrl_i         = '0;
    {stall_lsu_i, stall_multdiv_i, stall_jump_i, stall_branch_i} = 4'b0000;
  endtask

  // keep every non-comment, non-empty line
  task automatic load_trace();
    int    fd;
    string line;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      $display("ERROR: cannot open trace file %s", TRACE_FILE);
      return;
    end
    while ($fgets(line, fd) > 0) begin
      if (line.len() > 1 && line.getc(0) != "#") begin
        lines.push_back(line);
      end
    end
    $fclose(fd);
  endtask

  // parse one line and apply its inputs, ok is low on a bad line
  task automatic drive_line(input string line, output bit ok);
    int n;
    n = $sscanf(line, "%b %b %b %b %b %h %h %h %h %b %d %b %h %h %b %b %b",
                f_ctl, f_dec, f_lsu, f_irq, f_stall, f_id, f_instr, f_cinstr, f_addr,
                e_pcset, e_pcmux, e_excpc, e_cause, e_mtval, e_strb, e_rdy, e_busy);
    ok = (n == 17);
    if (ok) begin
      {fetch_enable_i, instr_valid_i, branch_set_i, jump_set_i} = f_ctl;
      {illegal_insn_i, ecall_insn_i, ebrk_insn_i, mret_insn_i,
       wfi_insn_i, csr_status_i, instr_is_compressed_i} = f_dec;
      {load_err_i, store_err_i}       = f_lsu;
      {irq_i, irq_req_ctrl_i, m_ie_i} = f_irq;
      {stall_lsu_i, stall_multdiv_i, stall_jump_i, stall_branch_i} = f_stall;
      irq_id_ctrl_i      = f_id;
      instr_i            = f_instr;
      instr_compressed_i = f_cinstr;
      lsu_addr_last_i    = f_addr;
    end
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
      mismatches++;
    end
  endtask

  task automatic check_outputs();
    check_val("pc_set_o", 32'(e_pcset), 32'(pc_set_o));
    check_val("pc_mux_o", 32'(e_pcmux), 32'(pc_mux_o));
    check_val("exc_pc_mux_o", 32'(e_excpc), 32'(exc_pc_mux_o));
    check_val("exc_cause_o", 32'(e_cause), 32'(exc_cause_o));
    check_val("csr_mtval_o", e_mtval, csr_mtval_o);
    // strobes, msb first as in the trace header
    check_val("first_fetch_o", 32'(e_strb[11]), 32'(first_fetch_o));
    check_val("instr_req_o", 32'(e_strb[10]), 32'(instr_req_o));
    check_val("irq_ack_o", 32'(e_strb[9]), 32'(irq_ack_o));
    check_val("exc_ack_o", 32'(e_strb[8]), 32'(exc_ack_o));
    check_val("csr_save_if_o", 32'(e_strb[7]), 32'(csr_save_if_o));
    check_val("csr_save_id_o", 32'(e_strb[6]), 32'(csr_save_id_o));
    check_val("csr_restore_mret_id_o", 32'(e_strb[5]), 32'(csr_restore_mret_id_o));
    check_val("csr_save_cause_o", 32'(e_strb[4]), 32'(csr_save_cause_o));
    check_val("perf_jump_o", 32'(e_strb[3]), 32'(perf_jump_o));
    check_val("perf_tbranch_o", 32'(e_strb[2]), 32'(perf_tbranch_o));
    check_val("instr_valid_clear_o", 32'(e_strb[1]), 32'(instr_valid_clear_o));
    check_val("id_out_valid_o", 32'(e_strb[0]), 32'(id_out_valid_o));
    check_val("id_in_ready_o", 32'(e_rdy), 32'(id_in_ready_o));
    check_val("ctrl_busy_o", 32'(e_busy), 32'(ctrl_busy_o));
    // acknowledged id goes out with irq_ack_o
    if (e_strb[9]) begin
      check_val("irq_id_o", 32'(f_id), 32'(irq_id_o));
    end
  endtask

  // boot address held, no fetch while in reset
  task automatic check_reset();
    check_val("pc_set_o", 32'd1, 32'(pc_set_o));
    check_val("pc_mux_o", 32'(PC_BOOT), 32'(pc_mux_o));
    check_val("instr_req_o", 32'd0, 32'(instr_req_o));
    check_val("ctrl_busy_o", 32'd1, 32'(ctrl_busy_o));
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    bit ok;
    init_inputs();
    rst_ni = 1'b0;
    load_trace();
    if (lines.size() == 0) begin
      $display("ERROR: trace file is missing or holds no stimulus lines");
      other_errors++;
    end else begin
      limit_cycles = lines.size() + 20;
      @(posedge clk_i);
      #60;
      check_reset();
      // release reset after two edges
      @(posedge clk_i);
      #10;
      rst_ni = 1'b1;
      foreach (lines[i]) begin
        drive_line(lines[i], ok);
        if (!ok) begin
          $display("ERROR: trace line %0d has the wrong number of fields", i + 1);
          other_errors++;
        end else begin
          // outputs settled well before the next edge
          #50;
          check_outputs();
        end
        @(posedge clk_i);
        #10;
      end
    end
    $display("checks: %0d, mismatches: %0d, other errors: %0d",
             checks, mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // cycle limit from the trace length
  initial begin
    wait (limit_cycles > 0);
    while (cycle_cnt < limit_cycles) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("ERROR: run did not end within %0d cycles", limit_cycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

//--- test/core_ctrl_trace.txt
# in:  ctl(en vld br jp) dec(ill ecl ebk mret wfi csr cmp) lsu(ld st) irq(irq req mie) stall(lsu md jp br) id instr cinstr addr
# exp: pc_set pc_mux exc_pc cause mtval strb(ff req iack eack sif sid mret scause pj pt vclr oval) rdy busy
0000 0000000 00 000 0000 00 00000000 0000 00000000 1 0 0 00 00000000 000000000010 1 1
1000 0000000 00 000 0000 00 00000000 0000 00000000 1 0 0 00 00000000 000000000010 1 1
1000 0000000 00 000 0000 00 00000000 0000 00000000 1 0 0 00 00000000 010000000010 1 1
1000 0000000 00 000 0000 00 00000000 0000 00000000 0 0 0 00 00000000 110000000010 1 1
1110 0000000 00 000 0000 00 00000000 0000 00000000 1 1 0 00 00000000 010000000111 1 1
1101 0000000 00 000 0010 00 00000000 0000 00000000 1 1 0 00 00000000 010000001000 0 1
1101 0000000 00 000 0000 00 00000000 0000 00000000 1 1 0 00 00000000 010000001011 1 1
1100 1000001 00 000 0000 00 12345678 9c3a 00000000 0 0 0 00 00000000 010000000011 0 1
1100 1000001 00 000 0000 00 12345678 9c3a 00000000 1 2 0 02 00009c3a 010001010011 0 1
1100 1000000 00 000 0000 00 deadbeef 9c3a 00000000 0 0 0 00 00000000 010000000011 0 1
1100 1000000 00 000 0000 00 deadbeef 9c3a 00000000 1 2 0 02 deadbeef 010001010011 0 1
1100 0100000 00 000 0000 00 00000073 0000 00000000 0 0 0 00 00000000 010000000011 0 1
1100 0100000 00 000 0000 00 00000073 0000 00000000 1 2 0 0b 00000000 010001010011 0 1
1100 0010000 00 000 0000 00 00100073 0000 00000000 0 0 0 00 00000000 010000000011 0 1
1100 0010000 00 000 0000 00 00100073 0000 00000000 1 2 0 03 00000000 010001010011 0 1
1100 0000000 10 000 0000 00 00000000 0000 00001ffc 0 0 0 00 00000000 010000000011 0 1
1100 0000000 00 000 0000 00 00000000 0000 00001ffc 1 2 0 05 00001ffc 010001010011 0 1
1100 0000000 11 000 0000 00 00000000 0000 00002000 0 0 0 00 00000000 010000000011 0 1
1100 0000000 00 000 0000 00 00000000 0000 00002000 1 2 0 07 00002000 010001010011 0 1
1000 0000000 00 011 0000 0b 00000000 0000 00000000 0 0 0 00 00000000 010000000010 0 1
1000 0000000 00 011 0000 0b 00000000 0000 00000000 1 2 1 2b 00000000 011110010010 1 1
1100 0000000 00 011 0100 03 00000000 0000 00000000 0 0 0 00 00000000 010000000000 0 1
1100 0000000 00 011 0000 03 00000000 0000 00000000 0 0 0 00 00000000 010000000011 0 1
1000 0000000 00 011 0000 03 00000000 0000 00000000 1 2 1 23 00000000 011110010010 1 1
1000 0000000 00 010 0000 03 00000000 0000 00000000 0 0 0 00 00000000 010000000010 1 1
1100 0001000 00 000 0000 00 00000000 0000 00000000 0 0 0 00 00000000 010000000011 0 1
1100 0001000 00 000 0000 00 00000000 0000 00000000 1 3 0 00 00000000 010000100011 0 1
1100 0000100 00 000 0000 00 00000000 0000 00000000 0 0 0 00 00000000 010000000011 0 1
1100 0000100 00 000 0000 00 00000000 0000 00000000 0 0 0 00 00000000 010000000011 0 1
1000 0000000 00 000 0000 00 00000000 0000 00000000 0 0 0 00 00000000 000000000010 0 0
1000 0000000 00 000 0000 00 00000000 0000 00000000 0 0 0 00 00000000 000000000010 0 0
1000 0000000 00 100 0000 00 00000000 0000 00000000 0 0 0 00 00000000 000000000010 0 0
1000 0000000 00 000 0000 00 00000000 0000 00000000 0 0 0 00 00000000 110000000010 1 1
1100 0000010 00 000 0000 00 00000000 0000 00000000 0 0 0 00 00000000 010000000011 0 1
1100 0000010 00 000 0000 00 00000000 0000 00000000 0 0 0 00 00000000 010000000011 0 1
1000 0000000 00 000 0000 00 00000000 0000 00000000 0 0 0 00 00000000 010000000010 1 1

//--- core_ctrl.f
hdl/core_ctrl_pkg.sv
hdl/exc_cause_if.sv
hdl/exc_cause_unit.sv
hdl/ctrl_fsm.sv
hdl/core_ctrl.sv
test/core_ctrl_tb.sv

//--- Makefile
# Verilator build and run of the core controller testbench
TOP := core_ctrl_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f core_ctrl.f --top-module $(TOP) -Mdir obj_dir

# pass only when the simulation prints the pass message
run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
